/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load dispatch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ldu_dq_tb \
    -f verilog.f -Mdir obj_dir -o ldu_dq_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/ldu_dq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

/* source/dq_dispatch_alloc.sv */
// combinational only; allocation uses occupancy at the start of the cycle, before any launch shift
`timescale 1ns/1ps

module dq_dispatch_alloc import ldu_dq_pkg::*; #(
    parameter int LDU_DQ_ENTRIES = 4
) (
    input  logic [LDU_DQ_ENTRIES-1:0]               valid_by_entry,

    input  logic [DISPATCH_WAYS-1:0]                dispatch_attempt_by_way,
    input  logic [DISPATCH_WAYS-1:0]                dispatch_valid_by_way,
    input  op_t [DISPATCH_WAYS-1:0]                 dispatch_op_by_way,
    input  imm12_t [DISPATCH_WAYS-1:0]              dispatch_imm12_by_way,
    input  pr_t [DISPATCH_WAYS-1:0]                 dispatch_a_pr_by_way,
    input  logic [DISPATCH_WAYS-1:0]                dispatch_a_ready_by_way,
    input  logic [DISPATCH_WAYS-1:0]                dispatch_a_is_zero_by_way,
    input  pr_t [DISPATCH_WAYS-1:0]                 dispatch_dest_pr_by_way,
    input  rob_index_t [DISPATCH_WAYS-1:0]          dispatch_rob_index_by_way,

    output logic [DISPATCH_WAYS-1:0]                dispatch_ack_by_way,

    output logic [LDU_DQ_ENTRIES-1:0]               dispatch_valid_by_entry,
    output op_t [LDU_DQ_ENTRIES-1:0]                dispatch_op_by_entry,
    output imm12_t [LDU_DQ_ENTRIES-1:0]             dispatch_imm12_by_entry,
    output pr_t [LDU_DQ_ENTRIES-1:0]                dispatch_a_pr_by_entry,
    output logic [LDU_DQ_ENTRIES-1:0]               dispatch_a_ready_by_entry,
    output logic [LDU_DQ_ENTRIES-1:0]               dispatch_a_is_zero_by_entry,
    output pr_t [LDU_DQ_ENTRIES-1:0]                dispatch_dest_pr_by_entry,
    output rob_index_t [LDU_DQ_ENTRIES-1:0]         dispatch_rob_index_by_entry
);

    // chosen entry per way, zero when the way gets nothing
    logic [DISPATCH_WAYS-1:0][LDU_DQ_ENTRIES-1:0] one_hot_by_way;

    // isolate the lowest set bit
    function automatic logic [LDU_DQ_ENTRIES-1:0] lowest_one(
        input logic [LDU_DQ_ENTRIES-1:0] mask
    );
        return mask & (~mask + LDU_DQ_ENTRIES'(1));
    endfunction

    // ----------------------------------------------------------------------
    // slot selection, way 0 first

    always_comb begin
        logic [LDU_DQ_ENTRIES-1:0] open_mask;
        open_mask = ~valid_by_entry;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            one_hot_by_way[w] = lowest_one(open_mask) & {LDU_DQ_ENTRIES{dispatch_attempt_by_way[w]}};
            dispatch_ack_by_way[w] = dispatch_attempt_by_way[w] & (|open_mask);
            // later ways only see what is left
            open_mask = open_mask & ~one_hot_by_way[w];
        end
    end

    // ----------------------------------------------------------------------
    // way to entry routing

    always_comb begin
        dispatch_valid_by_entry     = '0;
        dispatch_op_by_entry        = '0;
        dispatch_imm12_by_entry     = '0;
        dispatch_a_pr_by_entry      = '0;
        dispatch_a_ready_by_entry   = '0;
        dispatch_a_is_zero_by_entry = '0;
        dispatch_dest_pr_by_entry   = '0;
        dispatch_rob_index_by_entry = '0;
        for (int e = 0; e < LDU_DQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (one_hot_by_way[w][e]) begin
                    dispatch_valid_by_entry[e]     |= dispatch_valid_by_way[w];
                    dispatch_op_by_entry[e]        |= dispatch_op_by_way[w];
                    dispatch_imm12_by_entry[e]     |= dispatch_imm12_by_way[w];
                    dispatch_a_pr_by_entry[e]      |= dispatch_a_pr_by_way[w];
                    dispatch_a_ready_by_entry[e]   |= dispatch_a_ready_by_way[w];
                    dispatch_a_is_zero_by_entry[e] |= dispatch_a_is_zero_by_way[w];
                    dispatch_dest_pr_by_entry[e]   |= dispatch_dest_pr_by_way[w];
                    dispatch_rob_index_by_entry[e] |= dispatch_rob_index_by_way[w];
                end
            end
        end
    end

    // an entry never takes two ops in one cycle
    always_comb begin
        logic [LDU_DQ_ENTRIES-1:0] taken;
        taken = '0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            assert ((taken & one_hot_by_way[w]) == '0)
                else $error("dispatch: entry chosen by two ways");
            taken = taken | one_hot_by_way[w];
        end
    end

endmodule

/* source/dq_entry_shift.sv */
// entry 0 is always the oldest op; launch needs both ready inputs and shifts every entry down one
`timescale 1ns/1ps

module dq_entry_shift import ldu_dq_pkg::*; #(
    parameter int LDU_DQ_ENTRIES = 4
) (
    input  logic                                CLK,
    input  logic                                nRST,

    input  logic [LDU_DQ_ENTRIES-1:0]           dispatch_valid_by_entry,
    input  op_t [LDU_DQ_ENTRIES-1:0]            dispatch_op_by_entry,
    input  imm12_t [LDU_DQ_ENTRIES-1:0]         dispatch_imm12_by_entry,
    input  pr_t [LDU_DQ_ENTRIES-1:0]            dispatch_a_pr_by_entry,
    input  logic [LDU_DQ_ENTRIES-1:0]           dispatch_a_ready_by_entry,
    input  logic [LDU_DQ_ENTRIES-1:0]           dispatch_a_is_zero_by_entry,
    input  pr_t [LDU_DQ_ENTRIES-1:0]            dispatch_dest_pr_by_entry,
    input  rob_index_t [LDU_DQ_ENTRIES-1:0]     dispatch_rob_index_by_entry,

    input  logic [LDU_DQ_ENTRIES-1:0]           new_a_ready_by_entry,
    input  logic [LDU_DQ_ENTRIES-1:0]           new_killed_by_entry,

    input  logic                                ldu_cq_enq_ready,
    input  logic                                ldu_iq_enq_ready,

    output logic [LDU_DQ_ENTRIES-1:0]           valid_by_entry,
    output pr_t [LDU_DQ_ENTRIES-1:0]            a_pr_by_entry,
    output rob_index_t [LDU_DQ_ENTRIES-1:0]     rob_index_by_entry,

    output logic                                ldu_cq_enq_valid,
    output logic                                ldu_cq_enq_killed,
    output op_t                                 ldu_cq_enq_op,
    output pr_t                                 ldu_cq_enq_dest_pr,
    output rob_index_t                          ldu_cq_enq_rob_index,

    output logic                                ldu_iq_enq_valid,
    output op_t                                 ldu_iq_enq_op,
    output imm12_t                              ldu_iq_enq_imm12,
    output pr_t                                 ldu_iq_enq_a_pr,
    output logic                                ldu_iq_enq_a_ready,
    output logic                                ldu_iq_enq_a_is_zero
);

    logic [LDU_DQ_ENTRIES-1:0]      killed_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]      a_ready_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]      a_is_zero_by_entry;
    op_t [LDU_DQ_ENTRIES-1:0]       op_by_entry;
    imm12_t [LDU_DQ_ENTRIES-1:0]    imm12_by_entry;
    pr_t [LDU_DQ_ENTRIES-1:0]       dest_pr_by_entry;

    logic launching;

    assign launching = valid_by_entry[0] & ldu_cq_enq_ready & ldu_iq_enq_ready;

    // ----------------------------------------------------------------------
    // control flags
    // source is self, or the entry above while launching

    always_ff @(posedge CLK) begin
        int src;
        if (!nRST) begin
            valid_by_entry   <= '0;
            killed_by_entry  <= '0;
            a_ready_by_entry <= '0;
        end else begin
            for (int i = 0; i < LDU_DQ_ENTRIES; i++) begin
                src = launching ? i + 1 : i;
                if (src >= LDU_DQ_ENTRIES) begin
                    // top entry empties on a launch
                    valid_by_entry[i] <= 1'b0;
                end else if (valid_by_entry[src]) begin
                    valid_by_entry[i]   <= 1'b1;
                    killed_by_entry[i]  <= killed_by_entry[src] | new_killed_by_entry[src];
                    a_ready_by_entry[i] <= a_ready_by_entry[src] | new_a_ready_by_entry[src];
                end else begin
                    valid_by_entry[i]   <= dispatch_valid_by_entry[src];
                    killed_by_entry[i]  <= 1'b0;
                    a_ready_by_entry[i] <= dispatch_a_ready_by_entry[src];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // payload, same source choice

    always_ff @(posedge CLK) begin
        int src;
        for (int i = 0; i < LDU_DQ_ENTRIES; i++) begin
            src = launching ? i + 1 : i;
            if (src < LDU_DQ_ENTRIES) begin
                if (valid_by_entry[src]) begin
                    op_by_entry[i]        <= op_by_entry[src];
                    imm12_by_entry[i]     <= imm12_by_entry[src];
                    a_pr_by_entry[i]      <= a_pr_by_entry[src];
                    a_is_zero_by_entry[i] <= a_is_zero_by_entry[src];
                    dest_pr_by_entry[i]   <= dest_pr_by_entry[src];
                    rob_index_by_entry[i] <= rob_index_by_entry[src];
                end else begin
                    op_by_entry[i]        <= dispatch_op_by_entry[src];
                    imm12_by_entry[i]     <= dispatch_imm12_by_entry[src];
                    a_pr_by_entry[i]      <= dispatch_a_pr_by_entry[src];
                    a_is_zero_by_entry[i] <= dispatch_a_is_zero_by_entry[src];
                    dest_pr_by_entry[i]   <= dispatch_dest_pr_by_entry[src];
                    rob_index_by_entry[i] <= dispatch_rob_index_by_entry[src];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // launch from entry 0, same-cycle wakeup and kill included

    assign ldu_cq_enq_valid     = launching;
    assign ldu_cq_enq_killed    = killed_by_entry[0] | new_killed_by_entry[0];
    assign ldu_cq_enq_op        = op_by_entry[0];
    assign ldu_cq_enq_dest_pr   = dest_pr_by_entry[0];
    assign ldu_cq_enq_rob_index = rob_index_by_entry[0];

    assign ldu_iq_enq_valid     = launching;
    assign ldu_iq_enq_op        = op_by_entry[0];
    assign ldu_iq_enq_imm12     = imm12_by_entry[0];
    assign ldu_iq_enq_a_pr      = a_pr_by_entry[0];
    assign ldu_iq_enq_a_ready   = a_ready_by_entry[0] | new_a_ready_by_entry[0];
    assign ldu_iq_enq_a_is_zero = a_is_zero_by_entry[0];

    // a stalled op stays in entry 0 until both queues take it
    assert property (@(posedge CLK) disable iff (!nRST)
        (valid_by_entry[0] && !ldu_cq_enq_valid)
            |=> (valid_by_entry[0] && $stable(rob_index_by_entry[0])))
        else $error("stalled op left entry 0");

endmodule

/* source/dq_status_check.sv */
// combinational only; writeback and kill inputs are single-cycle strobes, killing is inclusive of the relative index
`timescale 1ns/1ps

module dq_status_check import ldu_dq_pkg::*; #(
    parameter int LDU_DQ_ENTRIES = 4
) (
    input  pr_t [LDU_DQ_ENTRIES-1:0]            a_pr_by_entry,
    input  rob_index_t [LDU_DQ_ENTRIES-1:0]     rob_index_by_entry,

    input  logic [PRF_BANK_COUNT-1:0]           wb_bus_valid_by_bank,
    input  upper_pr_t [PRF_BANK_COUNT-1:0]      wb_bus_upper_pr_by_bank,

    input  logic                                rob_kill_valid,
    input  rob_index_t                          rob_kill_abs_head_index,
    input  rob_index_t                          rob_kill_rel_kill_younger_index,

    output logic [LDU_DQ_ENTRIES-1:0]           new_a_ready_by_entry,
    output logic [LDU_DQ_ENTRIES-1:0]           new_killed_by_entry
);

    always_comb begin
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        upper_pr_t upper_tag;
        rob_index_t rel_index;
        for (int i = 0; i < LDU_DQ_ENTRIES; i++) begin
            // ------------------------------------------------------------------
            // wakeup on the bank that owns operand A
            bank      = a_pr_by_entry[i][LOG_PRF_BANK_COUNT-1:0];
            upper_tag = a_pr_by_entry[i][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
            new_a_ready_by_entry[i] = wb_bus_valid_by_bank[bank]
                & (wb_bus_upper_pr_by_bank[bank] == upper_tag);

            // ------------------------------------------------------------------
            // age relative to ROB head, wraps around
            rel_index = rob_index_by_entry[i] - rob_kill_abs_head_index;
            new_killed_by_entry[i] = rob_kill_valid
                & (rel_index >= rob_kill_rel_kill_younger_index);
        end
    end

endmodule

/* source/ldu_dq.sv */
// queue depth set here and passed down; dispatch ack is combinational and ops must be held until acked
`timescale 1ns/1ps

module ldu_dq import ldu_dq_pkg::*; #(
    parameter int LDU_DQ_ENTRIES = 4
) (
    input  logic                                CLK,
    input  logic                                nRST,

    // dispatch by way
    input  logic [DISPATCH_WAYS-1:0]            dispatch_attempt_by_way,
    input  logic [DISPATCH_WAYS-1:0]            dispatch_valid_by_way,
    input  op_t [DISPATCH_WAYS-1:0]             dispatch_op_by_way,
    input  imm12_t [DISPATCH_WAYS-1:0]          dispatch_imm12_by_way,
    input  pr_t [DISPATCH_WAYS-1:0]             dispatch_a_pr_by_way,
    input  logic [DISPATCH_WAYS-1:0]            dispatch_a_ready_by_way,
    input  logic [DISPATCH_WAYS-1:0]            dispatch_a_is_zero_by_way,
    input  pr_t [DISPATCH_WAYS-1:0]             dispatch_dest_pr_by_way,
    input  rob_index_t [DISPATCH_WAYS-1:0]      dispatch_rob_index_by_way,
    output logic [DISPATCH_WAYS-1:0]            dispatch_ack_by_way,

    // writeback bus
    input  logic [PRF_BANK_COUNT-1:0]           wb_bus_valid_by_bank,
    input  upper_pr_t [PRF_BANK_COUNT-1:0]      wb_bus_upper_pr_by_bank,

    // central queue
    output logic                                ldu_cq_enq_valid,
    output logic                                ldu_cq_enq_killed,
    output op_t                                 ldu_cq_enq_op,
    output pr_t                                 ldu_cq_enq_dest_pr,
    output rob_index_t                          ldu_cq_enq_rob_index,
    input  logic                                ldu_cq_enq_ready,

    // issue queue
    output logic                                ldu_iq_enq_valid,
    output op_t                                 ldu_iq_enq_op,
    output imm12_t                              ldu_iq_enq_imm12,
    output pr_t                                 ldu_iq_enq_a_pr,
    output logic                                ldu_iq_enq_a_ready,
    output logic                                ldu_iq_enq_a_is_zero,
    input  logic                                ldu_iq_enq_ready,

    // ROB kill
    input  logic                                rob_kill_valid,
    input  rob_index_t                          rob_kill_abs_head_index,
    input  rob_index_t                          rob_kill_rel_kill_younger_index
);

    // ----------------------------------------------------------------------
    // entry state seen by allocation and status check

    logic [LDU_DQ_ENTRIES-1:0]          valid_by_entry;
    pr_t [LDU_DQ_ENTRIES-1:0]           a_pr_by_entry;
    rob_index_t [LDU_DQ_ENTRIES-1:0]    rob_index_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]          new_a_ready_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]          new_killed_by_entry;

    // routed dispatch
    logic [LDU_DQ_ENTRIES-1:0]          dispatch_valid_by_entry;
    op_t [LDU_DQ_ENTRIES-1:0]           dispatch_op_by_entry;
    imm12_t [LDU_DQ_ENTRIES-1:0]        dispatch_imm12_by_entry;
    pr_t [LDU_DQ_ENTRIES-1:0]           dispatch_a_pr_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]          dispatch_a_ready_by_entry;
    logic [LDU_DQ_ENTRIES-1:0]          dispatch_a_is_zero_by_entry;
    pr_t [LDU_DQ_ENTRIES-1:0]           dispatch_dest_pr_by_entry;
    rob_index_t [LDU_DQ_ENTRIES-1:0]    dispatch_rob_index_by_entry;

    dq_dispatch_alloc #(.LDU_DQ_ENTRIES(LDU_DQ_ENTRIES)) u_alloc (.*);

    dq_status_check #(.LDU_DQ_ENTRIES(LDU_DQ_ENTRIES)) u_status (.*);

    dq_entry_shift #(.LDU_DQ_ENTRIES(LDU_DQ_ENTRIES)) u_entries (.*);

endmodule

/* source/ldu_dq_pkg.sv */
// widths assume 128 physical registers over 4 writeback banks, a 128-entry ROB and 4 dispatch ways

package ldu_dq_pkg;

    // ----------------------------------------------------------------------
    // core widths

    localparam int DISPATCH_WAYS      = 4;
    localparam int LOG_PR_COUNT       = 7;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_ROB_ENTRIES    = 7;

    // ----------------------------------------------------------------------
    // vector types

    // low bits pick the bank, upper bits are the tag inside that bank
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // what the writeback bus carries per bank
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;

    // wraps modulo 2**LOG_ROB_ENTRIES
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

    typedef logic [3:0] op_t;
    typedef logic [11:0] imm12_t;

endpackage

/* tb/clock_gen.sv */
// free-running clock from time zero; reset is released by a non-blocking update on a rising edge
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK,
    output logic nRST
);

    initial CLK = 1'b0;

    always #(PERIOD_NS / 2) CLK = ~CLK;

    // hold reset for a whole number of cycles
    initial begin
        nRST <= 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

/* tb/ldu_dq_input.txt */
// id mode attempt valid ops robs a_prs a_ready wb_valid wb_tags kill head rel ready(cq,iq)
// then expected: ack launch_valid op rob a_ready killed; mode 1 rows get random payload
// test 1, reset then four acks on an empty queue
1 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 0 0 00 0 0
1 0 f f 4321 13121110 00000000 f 0 00000000 0 00 00 0  f 0 0 00 0 0
// test 2, full queue then three entries filled
2 0 f f 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0
2 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 1 10 1 0
2 0 f f 8765 17161514 00000000 f 0 00000000 0 00 00 0  1 0 0 00 0 0
// test 3, launch order, dispatch during a launch
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 2 11 1 0
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 3 12 1 0
3 0 3 3 0076 00001918 00000000 3 0 00000000 0 00 00 3  3 1 4 13 1 0
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 5 14 1 0
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 6 18 1 0
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 7 19 1 0
3 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 0 0 00 0 0
// test 4, back-pressure from either queue
4 0 3 3 0098 00002120 00000000 3 0 00000000 0 00 00 0  3 0 0 00 0 0
4 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 2  0 0 0 00 0 0
4 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 1  0 0 0 00 0 0
4 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0
4 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 8 20 1 0
4 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 9 21 1 0
// test 5, wakeup on bank 1 tag 0b; op b has the wrong tag, op c the wrong bank
5 0 7 7 0cba 00323130 002e312d 0 0 00000000 0 00 00 0  7 0 0 00 0 0
5 0 0 0 0000 00000000 00000000 0 a 0b000b00 0 00 00 0  0 0 0 00 0 0
5 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 a 30 1 0
5 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 b 31 0 0
5 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 c 32 0 0
// test 6, kill with head 120 and relative index 5
6 0 7 7 0fed 00027a7d 00000000 7 0 00000000 0 00 00 0  7 0 0 00 0 0
6 0 0 0 0000 00000000 00000000 0 0 00000000 1 78 05 0  0 0 0 00 0 0
6 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 d 7d 1 1
6 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 e 7a 1 0
6 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 1 f 02 1 1
6 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 3  0 0 0 00 0 0
// test 7, random background on an idle queue
7 1 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0
7 1 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0
7 1 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0
0 0 0 0 0000 00000000 00000000 0 0 00000000 0 00 00 0  0 0 0 00 0 0

/* tb/ldu_dq_tb.sv */
// run from the project root; imm12, dest_pr and a_is_zero are derived from op and ROB index
`timescale 1ns/1ps

module ldu_dq_tb
    import ldu_dq_pkg::*;
();

    localparam int ROW_WORDS     = 20;
    localparam int MAX_ROWS      = 64;
    localparam int RESET_TIMEOUT = 40;

    logic                               CLK;
    logic                               nRST;
    logic [DISPATCH_WAYS-1:0]           dispatch_attempt_by_way;
    logic [DISPATCH_WAYS-1:0]           dispatch_valid_by_way;
    op_t [DISPATCH_WAYS-1:0]            dispatch_op_by_way;
    imm12_t [DISPATCH_WAYS-1:0]         dispatch_imm12_by_way;
    pr_t [DISPATCH_WAYS-1:0]            dispatch_a_pr_by_way;
    logic [DISPATCH_WAYS-1:0]           dispatch_a_ready_by_way;
    logic [DISPATCH_WAYS-1:0]           dispatch_a_is_zero_by_way;
    pr_t [DISPATCH_WAYS-1:0]            dispatch_dest_pr_by_way;
    rob_index_t [DISPATCH_WAYS-1:0]     dispatch_rob_index_by_way;
    logic [DISPATCH_WAYS-1:0]           dispatch_ack_by_way;
    logic [PRF_BANK_COUNT-1:0]          wb_bus_valid_by_bank;
    upper_pr_t [PRF_BANK_COUNT-1:0]     wb_bus_upper_pr_by_bank;
    logic                               ldu_cq_enq_valid;
    logic                               ldu_cq_enq_killed;
    op_t                                ldu_cq_enq_op;
    pr_t                                ldu_cq_enq_dest_pr;
    rob_index_t                         ldu_cq_enq_rob_index;
    logic                               ldu_cq_enq_ready;
    logic                               ldu_iq_enq_valid;
    op_t                                ldu_iq_enq_op;
    imm12_t                             ldu_iq_enq_imm12;
    pr_t                                ldu_iq_enq_a_pr;
    logic                               ldu_iq_enq_a_ready;
    logic                               ldu_iq_enq_a_is_zero;
    logic                               ldu_iq_enq_ready;
    logic                               rob_kill_valid;
    rob_index_t                         rob_kill_abs_head_index;
    rob_index_t                         rob_kill_rel_kill_younger_index;

    // one row of the data file per cycle, ROW_WORDS words each
    logic [31:0] stim [0:ROW_WORDS*MAX_ROWS-1];
    // operand A tag of each acked dispatch, looked up by ROB index
    pr_t dispatched_a_pr [0:2**LOG_ROB_ENTRIES-1];
    int seed = 97632;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clock (.CLK(CLK), .nRST(nRST));

    ldu_dq #(.LDU_DQ_ENTRIES(4)) uut (.*);

    function automatic imm12_t imm_for(input op_t op, input rob_index_t rob);
        return {op, rob, 1'b1};
    endfunction

    function automatic pr_t dest_for(input rob_index_t rob);
        return rob ^ 7'h55;
    endfunction

    task automatic compare_value(input int row, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED row %0d: %s = %h, expected %h", row, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus

    task automatic drive_row(input int base);
        logic [31:0] f [ROW_WORDS];
        rob_index_t rob;
        op_t op;
        for (int k = 0; k < ROW_WORDS; k++) begin
            f[k] = stim[base+k];
        end
        if (f[1] == 32'd1) begin
            // background row, random payload with no attempt and no ready
            for (int k = 3; k < 13; k++) begin
                f[k] = $random(seed);
            end
            f[2]  = '0;
            f[13] = '0;
        end
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            rob = f[5][8*w +: 7];
            op  = f[4][4*w +: 4];
            dispatch_op_by_way[w]        <= op;
            dispatch_rob_index_by_way[w] <= rob;
            dispatch_imm12_by_way[w]     <= imm_for(op, rob);
            dispatch_dest_pr_by_way[w]   <= dest_for(rob);
            dispatch_a_is_zero_by_way[w] <= rob[0];
            dispatch_a_pr_by_way[w]      <= f[6][8*w +: 7];
            if (f[2][w] && stim[base+14][w]) begin
                dispatched_a_pr[rob] = f[6][8*w +: 7];
            end
        end
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            wb_bus_upper_pr_by_bank[b] <= f[9][8*b +: 5];
        end
        dispatch_attempt_by_way         <= f[2][3:0];
        dispatch_valid_by_way           <= f[3][3:0];
        dispatch_a_ready_by_way         <= f[7][3:0];
        wb_bus_valid_by_bank            <= f[8][3:0];
        rob_kill_valid                  <= f[10][0];
        rob_kill_abs_head_index         <= f[11][6:0];
        rob_kill_rel_kill_younger_index <= f[12][6:0];
        ldu_cq_enq_ready                <= f[13][1];
        ldu_iq_enq_ready                <= f[13][0];
    endtask

    // ------------------------------------------------------------------
    // checking

    task automatic check_row(input int base, input int row);
        logic [3:0] exp_ack;
        logic exp_valid;
        op_t exp_op;
        rob_index_t exp_rob;
        exp_ack   = stim[base+14][3:0];
        exp_valid = stim[base+15][0];
        exp_op    = stim[base+16][3:0];
        exp_rob   = stim[base+17][6:0];
        // background rows must leave the queue alone
        if (stim[base+1] == 32'd1) begin
            exp_ack   = '0;
            exp_valid = 1'b0;
        end
        compare_value(row, "dispatch_ack_by_way", 32'(dispatch_ack_by_way), 32'(exp_ack));
        compare_value(row, "ldu_cq_enq_valid", 32'(ldu_cq_enq_valid), 32'(exp_valid));
        compare_value(row, "ldu_iq_enq_valid", 32'(ldu_iq_enq_valid), 32'(exp_valid));
        if (exp_valid) begin
            compare_value(row, "ldu_cq_enq_op", 32'(ldu_cq_enq_op), 32'(exp_op));
            compare_value(row, "ldu_iq_enq_op", 32'(ldu_iq_enq_op), 32'(exp_op));
            compare_value(row, "ldu_cq_enq_rob_index", 32'(ldu_cq_enq_rob_index), 32'(exp_rob));
            compare_value(row, "ldu_cq_enq_dest_pr", 32'(ldu_cq_enq_dest_pr),
                          32'(dest_for(exp_rob)));
            compare_value(row, "ldu_iq_enq_imm12", 32'(ldu_iq_enq_imm12),
                          32'(imm_for(exp_op, exp_rob)));
            compare_value(row, "ldu_iq_enq_a_pr", 32'(ldu_iq_enq_a_pr),
                          32'(dispatched_a_pr[exp_rob]));
            compare_value(row, "ldu_iq_enq_a_is_zero", 32'(ldu_iq_enq_a_is_zero),
                          32'(exp_rob[0]));
            compare_value(row, "ldu_iq_enq_a_ready", 32'(ldu_iq_enq_a_ready),
                          32'(stim[base+18][0]));
            compare_value(row, "ldu_cq_enq_killed", 32'(ldu_cq_enq_killed),
                          32'(stim[base+19][0]));
        end
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", id, test_errors);
        end
        test_errors = 0;
    endtask

    // a row with id 0 ends the data
    task automatic run_rows();
        int row;
        int base;
        row = 0;
        while (row < MAX_ROWS && stim[row*ROW_WORDS] != 32'd0) begin
            base = row * ROW_WORDS;
            @(posedge CLK);
            drive_row(base);
            @(negedge CLK);
            check_row(base, row + 1);
            row++;
            if (row == MAX_ROWS || stim[row*ROW_WORDS] != stim[base]) begin
                report_test(stim[base]);
            end
        end
    endtask

    initial begin
        int cycles;
        dispatch_attempt_by_way         <= '0;
        dispatch_valid_by_way           <= '0;
        dispatch_op_by_way              <= '0;
        dispatch_imm12_by_way           <= '0;
        dispatch_a_pr_by_way            <= '0;
        dispatch_a_ready_by_way         <= '0;
        dispatch_a_is_zero_by_way       <= '0;
        dispatch_dest_pr_by_way         <= '0;
        dispatch_rob_index_by_way       <= '0;
        wb_bus_valid_by_bank            <= '0;
        wb_bus_upper_pr_by_bank         <= '0;
        ldu_cq_enq_ready                <= 1'b0;
        ldu_iq_enq_ready                <= 1'b0;
        rob_kill_valid                  <= 1'b0;
        rob_kill_abs_head_index         <= '0;
        rob_kill_rel_kill_younger_index <= '0;
        $readmemh("tb/ldu_dq_input.txt", stim);
        cycles = 0;
        while (nRST !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            run_rows();
            $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                     tests_passed, tests_failed, checks, errors);
            if (errors == 0 && tests_passed > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

/* verilog.f */
source/ldu_dq_pkg.sv
source/dq_dispatch_alloc.sv
source/dq_status_check.sv
source/dq_entry_shift.sv
source/ldu_dq.sv
tb/clock_gen.sv
tb/ldu_dq_tb.sv
